//--- source/stream_pkg.sv
`default_nettype none

package stream_pkg;

    // ==================================================
    // Packet datapath
    // ==================================================

    // One stream beat
    typedef logic [63:0] data_t;

    // Ingress port tag, four ports
    typedef logic [1:0]  port_t;

    // Egress destination from the route table
    typedef logic [2:0]  egr_dest_t;

    // Free-running external time value
    typedef logic [63:0] timestamp_t;

    // ==================================================
    // Meter counters
    // ==================================================

    typedef logic [31:0] beat_cnt_t;
    typedef logic [31:0] pkt_cnt_t;

    // Count of port_t values
    localparam int NUM_PORTS = 4;

endpackage

`default_nettype wire

//--- source/regmap_pkg.sv
`default_nettype none

package regmap_pkg;

    // ==================================================
    // Register bus types
    // ==================================================

    // Byte address
    typedef logic [11:0] reg_addr_t;

    // Register word
    typedef logic [31:0] reg_data_t;

    // ==================================================
    // Region bases
    // ==================================================

    // Route table, one word per entry
    localparam reg_addr_t ROUTE_BASE = 12'h000;

    // Per-port packet counters, one word per port
    localparam reg_addr_t METER_BASE = 12'h100;

    // Beat counter offset within the meter region
    localparam reg_addr_t METER_BEAT_OFS = 12'h010;

    // ==================================================
    // Route entry fields
    // ==================================================

    localparam int ROUTE_DEST_LSB = 0;
    localparam int ROUTE_DROP_BIT = 3;

endpackage

`default_nettype wire

//--- source/route_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module route_lookup #(
    parameter int KEY_WID = 4
) (
    input  wire                         axil_if,
    input  wire                         rst_n,
    input  wire                         s_valid,
    input  wire stream_pkg::data_t      s_data,
    input  wire                         s_last,
    input  wire                         reg_wr,
    input  wire                         reg_rd,
    input  wire regmap_pkg::reg_addr_t  reg_addr,
    input  wire regmap_pkg::reg_data_t  reg_wdata,
    output stream_pkg::egr_dest_t       lk_dest,
    output logic                        lk_drop,
    output logic                        rt_rd_hit,
    output regmap_pkg::reg_data_t       rt_rd_data
);

    localparam int NUM_ENT = 1 << KEY_WID;
    localparam int DEST_W  = $bits(stream_pkg::egr_dest_t);
    localparam regmap_pkg::reg_addr_t ROUTE_SPAN = regmap_pkg::reg_addr_t'(4 << KEY_WID);

    stream_pkg::egr_dest_t  dest_tbl [NUM_ENT];
    logic                   drop_tbl [NUM_ENT];

    logic                   sop_pend;
    logic [KEY_WID-1:0]     key;
    regmap_pkg::reg_addr_t  rt_ofs;
    logic [KEY_WID-1:0]     rt_idx;
    logic                   rt_hit;
    regmap_pkg::reg_data_t  rd_entry;

    // Key from the low bits of the first beat
    assign key = s_data[KEY_WID-1:0];

    // Register decode, wraps below the base so one compare is enough
    assign rt_ofs = reg_addr - regmap_pkg::ROUTE_BASE;
    assign rt_idx = rt_ofs[KEY_WID+1:2];
    assign rt_hit = (rt_ofs < ROUTE_SPAN);

    always_comb begin
        rd_entry = '0;
        rd_entry[regmap_pkg::ROUTE_DEST_LSB +: DEST_W] = dest_tbl[rt_idx];
        rd_entry[regmap_pkg::ROUTE_DROP_BIT] = drop_tbl[rt_idx];
    end

    // ==================================================
    // Table, start of packet and lookup
    // ==================================================

    always_ff @(posedge axil_if or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_ENT; i++) begin
                dest_tbl[i] <= '0;
                drop_tbl[i] <= 1'b0;
            end
            sop_pend  <= 1'b1;
            lk_dest   <= '0;
            lk_drop   <= 1'b0;
            rt_rd_hit <= 1'b0;
        end else begin
            if (reg_wr && rt_hit) begin
                dest_tbl[rt_idx] <= reg_wdata[regmap_pkg::ROUTE_DEST_LSB +: DEST_W];
                drop_tbl[rt_idx] <= reg_wdata[regmap_pkg::ROUTE_DROP_BIT];
            end
            if (s_valid) begin
                sop_pend <= s_last;
            end
            // Old table contents if a write lands on the same edge
            if (s_valid && sop_pend) begin
                lk_dest <= dest_tbl[key];
                lk_drop <= drop_tbl[key];
            end
            rt_rd_hit <= reg_rd && rt_hit;
        end
    end

    // Read-back word
    always_ff @(posedge axil_if) begin
        rt_rd_data <= rd_entry;
    end

endmodule

`default_nettype wire

//--- source/pkt_meter.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_meter (
    input  wire                         axil_if,
    input  wire                         rst_n,
    input  wire                         s_valid,
    input  wire                         s_last,
    input  wire stream_pkg::port_t      s_tid,
    input  wire stream_pkg::timestamp_t timestamp,
    input  wire                         reg_rd,
    input  wire regmap_pkg::reg_addr_t  reg_addr,
    output stream_pkg::timestamp_t      mt_tstamp,
    output logic                        mt_rd_hit,
    output regmap_pkg::reg_data_t       mt_rd_data
);

    localparam int PORT_W = $bits(stream_pkg::port_t);
    localparam regmap_pkg::reg_addr_t PKT_SPAN =
        regmap_pkg::reg_addr_t'(4 * stream_pkg::NUM_PORTS);

    stream_pkg::pkt_cnt_t   pkt_cnt [stream_pkg::NUM_PORTS];
    stream_pkg::beat_cnt_t  beat_cnt;
    logic                   sop_pend;

    regmap_pkg::reg_addr_t  mt_ofs;
    stream_pkg::port_t      rd_port;
    logic                   pkt_hit;
    logic                   beat_hit;

    // Register decode relative to the meter base
    assign mt_ofs   = reg_addr - regmap_pkg::METER_BASE;
    assign rd_port  = mt_ofs[PORT_W+1:2];
    assign pkt_hit  = (mt_ofs < PKT_SPAN);
    assign beat_hit = ((mt_ofs >> 2) == (regmap_pkg::METER_BEAT_OFS >> 2));

    // ==================================================
    // Counters and timestamp capture
    // ==================================================

    always_ff @(posedge axil_if or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < stream_pkg::NUM_PORTS; p++) begin
                pkt_cnt[p] <= '0;
            end
            beat_cnt  <= '0;
            sop_pend  <= 1'b1;
            mt_rd_hit <= 1'b0;
        end else begin
            if (s_valid) begin
                beat_cnt <= beat_cnt + 1'b1;
                sop_pend <= s_last;
            end
            // Dropped packets are counted as well
            if (s_valid && sop_pend) begin
                pkt_cnt[s_tid] <= pkt_cnt[s_tid] + 1'b1;
            end
            mt_rd_hit <= reg_rd && (pkt_hit || beat_hit);
        end
    end

    // Timestamp held until the next start of packet
    always_ff @(posedge axil_if) begin
        if (s_valid && sop_pend) begin
            mt_tstamp <= timestamp;
        end
    end

    // Read-back, one cycle after the strobe
    always_ff @(posedge axil_if) begin
        if (beat_hit) begin
            mt_rd_data <= regmap_pkg::reg_data_t'(beat_cnt);
        end else begin
            mt_rd_data <= regmap_pkg::reg_data_t'(pkt_cnt[rd_port]);
        end
    end

endmodule

`default_nettype wire

//--- source/egress_merge.sv
`timescale 1ns/1ps
`default_nettype none

module egress_merge (
    input  wire                         axil_if,
    input  wire                         rst_n,
    input  wire                         s_valid,
    input  wire stream_pkg::data_t      s_data,
    input  wire                         s_last,
    input  wire stream_pkg::port_t      s_tid,
    input  wire stream_pkg::egr_dest_t  lk_dest,
    input  wire                         lk_drop,
    input  wire stream_pkg::timestamp_t mt_tstamp,
    input  wire                         reg_rd,
    input  wire                         rt_rd_hit,
    input  wire regmap_pkg::reg_data_t  rt_rd_data,
    input  wire                         mt_rd_hit,
    input  wire regmap_pkg::reg_data_t  mt_rd_data,
    output logic                        m_valid,
    output stream_pkg::data_t           m_data,
    output logic                        m_last,
    output stream_pkg::port_t           m_tid,
    output stream_pkg::egr_dest_t       m_dest,
    output stream_pkg::timestamp_t      m_tuser,
    output logic                        rd_valid,
    output regmap_pkg::reg_data_t       rd_data
);

    // First stage copy of the beat
    logic                   d1_valid;
    stream_pkg::data_t      d1_data;
    logic                   d1_last;
    stream_pkg::port_t      d1_tid;

    // Read strobe delay
    logic                   rd_d1;
    regmap_pkg::reg_data_t  rd_sel;

    // ==================================================
    // Control stages
    // ==================================================

    always_ff @(posedge axil_if or negedge rst_n) begin
        if (!rst_n) begin
            d1_valid <= 1'b0;
            m_valid  <= 1'b0;
            rd_d1    <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            d1_valid <= s_valid;
            // Lookup result now belongs to the packet of the held beat
            m_valid  <= d1_valid && !lk_drop;
            rd_d1    <= reg_rd;
            rd_valid <= rd_d1;
        end
    end

    // ==================================================
    // Beat payload
    // ==================================================

    always_ff @(posedge axil_if) begin
        d1_data <= s_data;
        d1_last <= s_last;
        d1_tid  <= s_tid;
        m_data  <= d1_data;
        m_last  <= d1_last;
        m_tid   <= d1_tid;
        m_dest  <= lk_dest;
        m_tuser <= mt_tstamp;
    end

    // Regions do not overlap, so at most one hit
    always_comb begin
        if (rt_rd_hit) begin
            rd_sel = rt_rd_data;
        end else if (mt_rd_hit) begin
            rd_sel = mt_rd_data;
        end else begin
            rd_sel = '0;
        end
    end

    always_ff @(posedge axil_if) begin
        rd_data <= rd_sel;
    end

endmodule

`default_nettype wire

//--- source/p4_app_top.sv
`timescale 1ns/1ps
`default_nettype none

module p4_app_top #(
    parameter int KEY_WID = 4
) (
    input  wire                         axil_if,
    input  wire                         rst_n,
    // Input stream
    input  wire                         s_valid,
    input  wire stream_pkg::data_t      s_data,
    input  wire                         s_last,
    input  wire stream_pkg::port_t      s_tid,
    input  wire stream_pkg::timestamp_t timestamp,
    // Register port
    input  wire                         reg_wr,
    input  wire                         reg_rd,
    input  wire regmap_pkg::reg_addr_t  reg_addr,
    input  wire regmap_pkg::reg_data_t  reg_wdata,
    // Output stream
    output wire                         m_valid,
    output wire stream_pkg::data_t      m_data,
    output wire                         m_last,
    output wire stream_pkg::port_t      m_tid,
    output wire stream_pkg::egr_dest_t  m_dest,
    output wire stream_pkg::timestamp_t m_tuser,
    // Read answer
    output wire                         rd_valid,
    output wire regmap_pkg::reg_data_t  rd_data
);

    // ==================================================
    // Block results
    // ==================================================

    stream_pkg::egr_dest_t  lk_dest;
    logic                   lk_drop;
    logic                   rt_rd_hit;
    regmap_pkg::reg_data_t  rt_rd_data;
    stream_pkg::timestamp_t mt_tstamp;
    logic                   mt_rd_hit;
    regmap_pkg::reg_data_t  mt_rd_data;

    route_lookup #(
        .KEY_WID (KEY_WID)
    ) u_route_lookup (
        .axil_if    (axil_if),
        .rst_n      (rst_n),
        .s_valid    (s_valid),
        .s_data     (s_data),
        .s_last     (s_last),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .lk_dest    (lk_dest),
        .lk_drop    (lk_drop),
        .rt_rd_hit  (rt_rd_hit),
        .rt_rd_data (rt_rd_data)
    );

    pkt_meter u_pkt_meter (
        .axil_if    (axil_if),
        .rst_n      (rst_n),
        .s_valid    (s_valid),
        .s_last     (s_last),
        .s_tid      (s_tid),
        .timestamp  (timestamp),
        .reg_rd     (reg_rd),
        .reg_addr   (reg_addr),
        .mt_tstamp  (mt_tstamp),
        .mt_rd_hit  (mt_rd_hit),
        .mt_rd_data (mt_rd_data)
    );

    // Output stage and read merge
    egress_merge u_egress_merge (
        .axil_if    (axil_if),
        .rst_n      (rst_n),
        .s_valid    (s_valid),
        .s_data     (s_data),
        .s_last     (s_last),
        .s_tid      (s_tid),
        .lk_dest    (lk_dest),
        .lk_drop    (lk_drop),
        .mt_tstamp  (mt_tstamp),
        .reg_rd     (reg_rd),
        .rt_rd_hit  (rt_rd_hit),
        .rt_rd_data (rt_rd_data),
        .mt_rd_hit  (mt_rd_hit),
        .mt_rd_data (mt_rd_data),
        .m_valid    (m_valid),
        .m_data     (m_data),
        .m_last     (m_last),
        .m_tid      (m_tid),
        .m_dest     (m_dest),
        .m_tuser    (m_tuser),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data)
    );

endmodule

`default_nettype wire

//--- sim/tb_sva.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sva (
    input  wire                         axil_if,
    input  wire                         rst_n,
    input  wire                         s_valid,
    input  wire                         reg_rd,
    input  wire                         m_valid,
    input  wire                         m_last,
    input  wire stream_pkg::egr_dest_t  m_dest,
    input  wire stream_pkg::timestamp_t m_tuser,
    input  wire                         rd_valid
);

    logic                   reset_fail  = 1'b0;
    logic                   read_fail   = 1'b0;
    logic                   beat_fail   = 1'b0;
    logic                   stable_fail = 1'b0;
    logic                   any_fail;

    // Output packet in progress, with its first-beat fields
    logic                   in_pkt;
    stream_pkg::egr_dest_t  pkt_dest;
    stream_pkg::timestamp_t pkt_tuser;

    assign any_fail = reset_fail | read_fail | beat_fail | stable_fail;

    always_ff @(posedge axil_if or negedge rst_n) begin
        if (!rst_n) begin
            in_pkt    <= 1'b0;
            pkt_dest  <= '0;
            pkt_tuser <= '0;
        end else if (m_valid) begin
            in_pkt <= !m_last;
            if (!in_pkt) begin
                pkt_dest  <= m_dest;
                pkt_tuser <= m_tuser;
            end
        end
    end

    // ==================================================
    // Timing and reset rules
    // ==================================================

    idle_in_reset: assert property (@(posedge axil_if) !rst_n |-> (!m_valid && !rd_valid))
        else begin
            $error("m_valid or rd_valid high during reset");
            reset_fail = 1'b1;
        end

    read_latency: assert property (@(posedge axil_if) disable iff (!rst_n)
        rd_valid == $past(reg_rd, 2))
        else begin
            $error("rd_valid not exactly two cycles after reg_rd");
            read_fail = 1'b1;
        end

    beat_source: assert property (@(posedge axil_if) disable iff (!rst_n)
        m_valid |-> $past(s_valid, 2))
        else begin
            $error("m_valid without an input beat two cycles earlier");
            beat_fail = 1'b1;
        end

    pkt_fields_stable: assert property (@(posedge axil_if) disable iff (!rst_n)
        (m_valid && in_pkt) |-> (m_dest == pkt_dest && m_tuser == pkt_tuser))
        else begin
            $error("m_dest or m_tuser changed within a packet");
            stable_fail = 1'b1;
        end

endmodule

bind p4_app_top tb_sva u_sva (
    .axil_if  (axil_if),
    .rst_n    (rst_n),
    .s_valid  (s_valid),
    .reg_rd   (reg_rd),
    .m_valid  (m_valid),
    .m_last   (m_last),
    .m_dest   (m_dest),
    .m_tuser  (m_tuser),
    .rd_valid (rd_valid)
);

`default_nettype wire

//--- sim/tb.sv
`timescale 1ns/1ps
`default_nettype none

module tb;

    localparam int KEY_WID    = 4;
    localparam int NUM_ENT    = 1 << KEY_WID;
    localparam int NUM_PKTS   = 150;
    localparam int MAX_CYCLES = 3000;

    typedef struct packed {
        int unsigned cyc;
        logic [63:0] data;
        logic        last;
        logic [1:0]  tid;
        logic [2:0]  dest;
        logic [63:0] tuser;
    } beat_exp_t;

    typedef struct packed {
        int unsigned cyc;
        logic [31:0] data;
    } read_exp_t;

    logic                           axil_if = 1'b0;
    logic                           rst_n;
    logic                           s_valid;
    stream_pkg::data_t              s_data;
    logic                           s_last;
    stream_pkg::port_t              s_tid;
    stream_pkg::timestamp_t         timestamp = 64'h0123_4567_0000_0000;
    logic                           reg_wr;
    logic                           reg_rd;
    regmap_pkg::reg_addr_t          reg_addr;
    regmap_pkg::reg_data_t          reg_wdata;
    wire                            m_valid;
    wire stream_pkg::data_t         m_data;
    wire                            m_last;
    wire stream_pkg::port_t         m_tid;
    wire stream_pkg::egr_dest_t     m_dest;
    wire stream_pkg::timestamp_t    m_tuser;
    wire                            rd_valid;
    wire regmap_pkg::reg_data_t     rd_data;

    // Reference model state
    logic [2:0]     tbl_dest [NUM_ENT] = '{default: '0};
    logic           tbl_drop [NUM_ENT] = '{default: 1'b0};
    int unsigned    pkt_sent [4] = '{default: 0};
    int unsigned    beats_sent = 0;
    logic           sop = 1'b1;
    logic [2:0]     cur_dest = '0;
    logic           cur_drop = 1'b0;
    logic [63:0]    cur_tuser = '0;
    int unsigned    cycle = 0;
    beat_exp_t      beat_q [$];
    read_exp_t      read_q [$];

    p4_app_top #(
        .KEY_WID (KEY_WID)
    ) uut (
        .axil_if   (axil_if),
        .rst_n     (rst_n),
        .s_valid   (s_valid),
        .s_data    (s_data),
        .s_last    (s_last),
        .s_tid     (s_tid),
        .timestamp (timestamp),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .m_valid   (m_valid),
        .m_data    (m_data),
        .m_last    (m_last),
        .m_tid     (m_tid),
        .m_dest    (m_dest),
        .m_tuser   (m_tuser),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data)
    );

    always #5 axil_if = ~axil_if;

    always @(negedge axil_if) begin
        timestamp <= timestamp + 64'd1;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        assert (got === exp) else begin
            fail_run($sformatf("error %s: expected 0x%0h, got 0x%0h", name, exp, got));
        end
    endtask

    // Register view of the model with zero outside both regions
    function automatic logic [31:0] model_read(input logic [11:0] addr);
        logic [31:0]        val;
        logic [KEY_WID-1:0] idx;
        val = '0;
        idx = addr[KEY_WID+1:2];
        if (addr < 12'(4 * NUM_ENT)) begin
            val[2:0] = tbl_dest[idx];
            val[3]   = tbl_drop[idx];
        end else if (addr >= 12'h100 && addr < 12'h110) begin
            val = pkt_sent[addr[3:2]];
        end else if (addr[11:2] == 10'h044) begin
            val = beats_sent;
        end
        return val;
    endfunction

    // ==================================================
    // Reference model on the rising edge
    // ==================================================

    always @(posedge axil_if) begin
        beat_exp_t b;
        read_exp_t r;
        cycle++;
        if (cycle >= MAX_CYCLES) begin
            fail_run("timeout: run exceeded the cycle limit");
        end
        if (rst_n) begin
            // Reads and lookups see the table before a write on this edge
            if (reg_rd) begin
                r.cyc  = cycle + 1;
                r.data = model_read(reg_addr);
                read_q.push_back(r);
            end
            if (s_valid) begin
                if (sop) begin
                    cur_dest  = tbl_dest[s_data[KEY_WID-1:0]];
                    cur_drop  = tbl_drop[s_data[KEY_WID-1:0]];
                    cur_tuser = timestamp;
                    pkt_sent[s_tid]++;
                end
                beats_sent++;
                sop = s_last;
                if (!cur_drop) begin
                    b.cyc   = cycle + 1;
                    b.data  = s_data;
                    b.last  = s_last;
                    b.tid   = s_tid;
                    b.dest  = cur_dest;
                    b.tuser = cur_tuser;
                    beat_q.push_back(b);
                end
            end
            if (reg_wr && reg_addr < 12'(4 * NUM_ENT)) begin
                tbl_dest[reg_addr[KEY_WID+1:2]] = reg_wdata[2:0];
                tbl_drop[reg_addr[KEY_WID+1:2]] = reg_wdata[3];
            end
        end
    end

    // ==================================================
    // Output checks on the falling edge
    // ==================================================

    always @(negedge axil_if) begin
        beat_exp_t b;
        read_exp_t r;
        if (uut.u_sva.any_fail) begin
            fail_run("a concurrent assertion failed");
        end
        if (m_valid) begin
            assert (beat_q.size() != 0) else fail_run("output beat with none expected");
            b = beat_q.pop_front();
            assert (b.cyc == cycle) else fail_run("output beat at the wrong cycle");
            check_val("m_data", m_data, b.data);
            check_val("m_last", 64'(m_last), 64'(b.last));
            check_val("m_tid", 64'(m_tid), 64'(b.tid));
            check_val("m_dest", 64'(m_dest), 64'(b.dest));
            check_val("m_tuser", m_tuser, b.tuser);
        end else if (beat_q.size() != 0 && beat_q[0].cyc <= cycle) begin
            fail_run("expected output beat is missing");
        end
        if (rd_valid) begin
            assert (read_q.size() != 0) else fail_run("read answer with no read pending");
            r = read_q.pop_front();
            assert (r.cyc == cycle) else fail_run("read answer at the wrong cycle");
            check_val("rd_data", 64'(rd_data), 64'(r.data));
        end else if (read_q.size() != 0 && read_q[0].cyc <= cycle) begin
            fail_run("expected read answer is missing");
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================

    task automatic drive(input logic bv, input logic [63:0] data, input logic last,
                         input logic [1:0] tid, input logic wr, input logic rd,
                         input logic [11:0] addr, input logic [31:0] wdata);
        @(negedge axil_if);
        s_valid   = bv;
        s_data    = data;
        s_last    = last;
        s_tid     = tid;
        reg_wr    = wr;
        reg_rd    = rd;
        reg_addr  = addr;
        reg_wdata = wdata;
    endtask

    task automatic idle_cycle();
        drive(1'b0, '0, 1'b0, '0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic reg_write(input logic [11:0] addr, input logic [31:0] wdata);
        drive(1'b0, '0, 1'b0, '0, 1'b1, 1'b0, addr, wdata);
    endtask

    task automatic reg_read(input logic [11:0] addr);
        drive(1'b0, '0, 1'b0, '0, 1'b0, 1'b1, addr, '0);
    endtask

    // Optional table write for the key's entry on the first beat
    task automatic send_packet(input logic [KEY_WID-1:0] key, input int len,
                               input logic [1:0] tid, input logic wr,
                               input logic [31:0] wdata);
        logic [63:0] data;
        for (int i = 0; i < len; i++) begin
            data = {$urandom, $urandom};
            if (i == 0) begin
                data[KEY_WID-1:0] = key;
            end
            drive(1'b1, data, i == len - 1, tid, wr && i == 0, 1'b0, 12'(4 * key), wdata);
        end
    endtask

    task automatic read_counters();
        for (int p = 0; p < 4; p++) begin
            reg_read(12'(12'h100 + 4 * p));
        end
        reg_read(12'h110);
    endtask

    initial begin
        logic [KEY_WID-1:0] key;
        logic [31:0]        wdata;
        void'($urandom(32'h50401378));
        rst_n     = 1'b0;
        s_valid   = 1'b0;
        s_data    = '0;
        s_last    = 1'b0;
        s_tid     = '0;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        repeat (2) @(posedge axil_if);
        @(negedge axil_if);
        rst_n = 1'b1;
        repeat (3) idle_cycle();

        // Reset contents
        for (int i = 0; i < NUM_ENT; i++) begin
            reg_read(12'(4 * i));
        end
        read_counters();

        // Table programming with every fourth entry set to drop
        for (int i = 0; i < NUM_ENT; i++) begin
            wdata    = $urandom;
            wdata[3] = (i % 4 == 3);
            reg_write(12'(4 * i), wdata);
        end
        for (int i = 0; i < NUM_ENT; i++) begin
            reg_read(12'(4 * i));
        end
        reg_read(12'h0c0);
        reg_read(12'h114);
        reg_read(12'h200);
        reg_read(12'hffc);

        // Random traffic with gaps of zero to three idle cycles
        for (int n = 0; n < NUM_PKTS; n++) begin
            send_packet(4'($urandom), int'(1 + $urandom % 8), 2'($urandom), 1'b0, '0);
            repeat ($urandom % 4) idle_cycle();
        end

        // Entry rewritten on the middle packet's first beat
        for (int k = 0; k < 3; k++) begin
            key        = 4'($urandom);
            wdata      = $urandom;
            wdata[3:0] = ~{tbl_drop[key], tbl_dest[key]};
            send_packet(key, 2, 2'($urandom), 1'b0, '0);
            send_packet(key, 3, 2'($urandom), 1'b1, wdata);
            send_packet(key, 2, 2'($urandom), 1'b0, '0);
        end

        repeat (3) idle_cycle();
        read_counters();
        idle_cycle();

        while (beat_q.size() != 0 || read_q.size() != 0) begin
            @(posedge axil_if);
        end
        repeat (3) idle_cycle();
        if (uut.u_sva.any_fail) begin
            fail_run("a concurrent assertion failed");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- flist.f
source/stream_pkg.sv
source/regmap_pkg.sv
source/route_lookup.sv
source/pkt_meter.sv
source/egress_merge.sv
source/p4_app_top.sv
sim/tb_sva.sv
sim/tb.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb -f flist.f -o tb_sim

# Simulator exit status is not used, the log decides
./obj_dir/tb_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
    echo "Simulation did not complete"
    exit 1
fi
echo "Simulation passed"
